/* design/sq_arith_pkg.sv */
/*
 * Number format of the redundant squarer.
 * Holds the default operand shape, the widths derived from it and the
 * coefficient and column types shared by the datapath and the testbench.
 * The top level takes its parameter defaults from here.
 */
package sq_arith_pkg;

   // Default operand shape
   localparam int WORD_LEN              = 16;
   localparam int BIT_LEN               = 17;
   localparam int NONREDUNDANT_ELEMENTS = 4;
   localparam int REDUNDANT_ELEMENTS    = 1;
   localparam int NUM_SEGMENTS          = 2;

   localparam int NUM_ELEMENTS     = NONREDUNDANT_ELEMENTS + REDUNDANT_ELEMENTS;
   localparam int SEGMENT_ELEMENTS = NONREDUNDANT_ELEMENTS / NUM_SEGMENTS;
   // Top segment carries the redundant extension
   localparam int MUL_ELEMENTS     = SEGMENT_ELEMENTS + REDUNDANT_ELEMENTS;
   localparam int PP_COLUMNS       = 2 * MUL_ELEMENTS - 1;
   localparam int PROD_ELEMENTS    = 2 * NUM_ELEMENTS;

   // Coefficient product, sum of up to MUL_ELEMENTS of them, then doubled
   localparam int PP_BIT_LEN  = 2 * BIT_LEN + $clog2(MUL_ELEMENTS) + 1;
   // Column holds a word plus the high part of the column below, over all products
   localparam int ACC_BIT_LEN = PP_BIT_LEN - WORD_LEN + 1 +
                                $clog2(NUM_SEGMENTS * NUM_SEGMENTS);

   typedef logic [BIT_LEN-1:0] coeff_t;

   // Same coefficient seen as a whole or as carry bits above a word
   typedef union packed {
      coeff_t value;
      struct packed {
         logic [BIT_LEN-WORD_LEN-1:0] carry;
         logic [WORD_LEN-1:0]         word;
      } part;
   } coeff_u;

   typedef logic [PP_BIT_LEN-1:0]  pp_col_t;
   typedef logic [ACC_BIT_LEN-1:0] acc_col_t;

endpackage

/* design/sq_sched_pkg.sv */
/*
 * Segment schedule of the squarer.
 * Lists the segment pairs in issue order, which of them are doubled,
 * the sequencer states and the drain latency after the last issue.
 */
package sq_sched_pkg;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      DRAIN,
      HOLD
   } seq_state_t;

   localparam int NUM_PRODUCTS = 3;

   typedef logic [0:0] seg_sel_t;
   typedef logic [$clog2(NUM_PRODUCTS)-1:0] prod_cnt_t;

   // Bit i belongs to product i: (0,0), (1,0), (1,1)
   localparam logic [NUM_PRODUCTS-1:0] PAIR_A = 3'b110;
   localparam logic [NUM_PRODUCTS-1:0] PAIR_B = 3'b100;

   // Off-diagonal pair counts twice
   localparam logic [NUM_PRODUCTS-1:0] PAIR_DOUBLE = 3'b010;

   // Multiplier register plus accumulator register
   localparam int DRAIN_CYCLES = 2;

endpackage

/* design/pp_if.sv */
/*
 * Segment product bus from the multiplier to the column accumulator.
 * One product per valid cycle, no back-pressure.
 */
`timescale 1ns/1ps

interface pp_if
   import sq_arith_pkg::*;
#(
   parameter int COLUMNS     = sq_arith_pkg::PP_COLUMNS,
   parameter int OFFSET_BITS = $clog2(sq_arith_pkg::PROD_ELEMENTS)
);

   logic                   pp_valid;
   pp_col_t                pp_cols [COLUMNS];
   // Output column of pp_cols[0]
   logic [OFFSET_BITS-1:0] pp_offset;
   logic                   pp_first;
   logic                   pp_last;

   modport producer (output pp_valid, pp_cols, pp_offset, pp_first, pp_last);
   modport consumer (input pp_valid, pp_cols, pp_offset, pp_first, pp_last);

endinterface

/* design/square_sequencer.sv */
/*
 * Control of the squarer.
 * Accepts an operand in IDLE, issues the segment pairs one per cycle,
 * waits for the pipeline to drain and holds the result until it is taken.
 */
`timescale 1ns/1ps

module square_sequencer
   import sq_sched_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   output logic     out_valid,
   input  logic     out_ready,
   output logic     load,
   output logic     issue,
   output seg_sel_t a_sel,
   output seg_sel_t b_sel,
   output logic     double,
   output logic     first,
   output logic     last
);

   seq_state_t state;
   seq_state_t state_next;
   // Pair index while issuing, drain cycle while draining
   prod_cnt_t  cnt;
   prod_cnt_t  cnt_next;

   assign in_ready  = (state == IDLE);
   assign out_valid = (state == HOLD);
   assign load      = in_valid && in_ready;
   assign issue     = (state == ISSUE);

   assign a_sel  = seg_sel_t'(PAIR_A[cnt]);
   assign b_sel  = seg_sel_t'(PAIR_B[cnt]);
   assign double = PAIR_DOUBLE[cnt];
   assign first  = issue && (cnt == '0);
   assign last   = issue && (cnt == prod_cnt_t'(NUM_PRODUCTS - 1));

   always_comb begin
      state_next = state;
      cnt_next   = cnt;
      case (state)
         IDLE: begin
            if (load) begin
               state_next = ISSUE;
               cnt_next   = '0;
            end
         end
         ISSUE: begin
            if (last) begin
               state_next = DRAIN;
               cnt_next   = '0;
            end
            else begin
               cnt_next = cnt + 1'b1;
            end
         end
         DRAIN: begin
            if (cnt == prod_cnt_t'(DRAIN_CYCLES - 1)) begin
               state_next = HOLD;
            end
            else begin
               cnt_next = cnt + 1'b1;
            end
         end
         HOLD: begin
            // Result leaves on the out_ready transfer
            if (out_ready) begin
               state_next = IDLE;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
         cnt   <= '0;
      end
      else begin
         state <= state_next;
         cnt   <= cnt_next;
      end
   end

endmodule

/* design/segment_multiplier.sv */
/*
 * Segment multiplier of the squarer.
 * Captures the operand on load, then forms one segment product per issue.
 * Column j is the sum of the coefficient products a[i]*b[j-i], doubled for
 * off-diagonal pairs, and is presented on the product bus one cycle later.
 */
`timescale 1ns/1ps

module segment_multiplier
   import sq_arith_pkg::*, sq_sched_pkg::*;
#(
   parameter int  NONREDUNDANT_ELEMENTS = sq_arith_pkg::NONREDUNDANT_ELEMENTS,
   parameter int  REDUNDANT_ELEMENTS    = sq_arith_pkg::REDUNDANT_ELEMENTS,
   parameter int  NUM_SEGMENTS          = sq_arith_pkg::NUM_SEGMENTS,
   localparam int NUM_ELEMENTS          = NONREDUNDANT_ELEMENTS + REDUNDANT_ELEMENTS
)(
   input  logic     clk,
   input  logic     load,
   input  logic     issue,
   input  seg_sel_t a_sel,
   input  seg_sel_t b_sel,
   input  logic     double,
   input  logic     first,
   input  logic     last,
   input  coeff_t   in_data [NUM_ELEMENTS],
   pp_if.producer   pp
);

   localparam int SEGMENT_ELEMENTS = NONREDUNDANT_ELEMENTS / NUM_SEGMENTS;
   localparam int MUL_ELEMENTS     = SEGMENT_ELEMENTS + REDUNDANT_ELEMENTS;
   localparam int PP_COLUMNS       = 2 * MUL_ELEMENTS - 1;
   localparam int OFFSET_BITS      = $clog2(2 * NUM_ELEMENTS);

   coeff_t  operand [NUM_ELEMENTS];
   coeff_t  a_seg [MUL_ELEMENTS];
   coeff_t  b_seg [MUL_ELEMENTS];
   pp_col_t cols [PP_COLUMNS];

   always_ff @(posedge clk) begin
      if (load) begin
         operand <= in_data;
      end
   end

   always_comb begin
      for (int l = 0; l < SEGMENT_ELEMENTS; l++) begin
         a_seg[l] = operand[int'(a_sel) * SEGMENT_ELEMENTS + l];
         b_seg[l] = operand[int'(b_sel) * SEGMENT_ELEMENTS + l];
      end
      // Redundant slots extend the top segment only, zero elsewhere
      for (int l = SEGMENT_ELEMENTS; l < MUL_ELEMENTS; l++) begin
         a_seg[l] = '0;
         b_seg[l] = '0;
         if (int'(a_sel) == NUM_SEGMENTS - 1) begin
            a_seg[l] = operand[NONREDUNDANT_ELEMENTS + l - SEGMENT_ELEMENTS];
         end
         if (int'(b_sel) == NUM_SEGMENTS - 1) begin
            b_seg[l] = operand[NONREDUNDANT_ELEMENTS + l - SEGMENT_ELEMENTS];
         end
      end
   end

   always_comb begin
      for (int j = 0; j < PP_COLUMNS; j++) begin
         cols[j] = '0;
      end
      for (int i = 0; i < MUL_ELEMENTS; i++) begin
         for (int k = 0; k < MUL_ELEMENTS; k++) begin
            cols[i+k] = cols[i+k] + pp_col_t'(a_seg[i]) * pp_col_t'(b_seg[k]);
         end
      end
      // a*b + b*a as one shift
      if (double) begin
         for (int j = 0; j < PP_COLUMNS; j++) begin
            cols[j] = cols[j] << 1;
         end
      end
   end

   always_ff @(posedge clk) begin
      pp.pp_valid <= issue;
      if (issue) begin
         pp.pp_cols   <= cols;
         pp.pp_offset <= OFFSET_BITS'((int'(a_sel) + int'(b_sel)) * SEGMENT_ELEMENTS);
         pp.pp_first  <= first;
         pp.pp_last   <= last;
      end
   end

endmodule

/* design/column_accumulator.sv */
/*
 * Column accumulator of the squarer.
 * Adds each segment product into the product columns at its offset.
 * The low word of a product column lands in its own column, the bits above
 * it in the next one. After the last product the columns are partially
 * reduced into out_data, which then holds until the next result.
 */
`timescale 1ns/1ps

module column_accumulator
   import sq_arith_pkg::*;
#(
   parameter int  WORD_LEN              = sq_arith_pkg::WORD_LEN,
   parameter int  BIT_LEN               = sq_arith_pkg::BIT_LEN,
   parameter int  NONREDUNDANT_ELEMENTS = sq_arith_pkg::NONREDUNDANT_ELEMENTS,
   parameter int  REDUNDANT_ELEMENTS    = sq_arith_pkg::REDUNDANT_ELEMENTS,
   parameter int  NUM_SEGMENTS          = sq_arith_pkg::NUM_SEGMENTS,
   localparam int NUM_ELEMENTS          = NONREDUNDANT_ELEMENTS + REDUNDANT_ELEMENTS,
   localparam int PROD_ELEMENTS         = 2 * NUM_ELEMENTS
)(
   input  logic    clk,
   pp_if.consumer  pp,
   output coeff_t  out_data [PROD_ELEMENTS]
);

   localparam int SEGMENT_ELEMENTS = NONREDUNDANT_ELEMENTS / NUM_SEGMENTS;
   localparam int MUL_ELEMENTS     = SEGMENT_ELEMENTS + REDUNDANT_ELEMENTS;
   localparam int PP_COLUMNS       = 2 * MUL_ELEMENTS - 1;

   acc_col_t acc [PROD_ELEMENTS];
   acc_col_t acc_next [PROD_ELEMENTS];
   coeff_u   red [PROD_ELEMENTS];
   logic     reduce_pending;

   // Running sum, low word and high part from below, through one 3:2 stage
   always_comb begin
      acc_col_t base;
      acc_col_t lo;
      acc_col_t hi;
      acc_col_t s;
      acc_col_t c;
      int       d;
      for (int k = 0; k < PROD_ELEMENTS; k++) begin
         d    = k - int'(pp.pp_offset);
         base = pp.pp_first ? '0 : acc[k];
         lo   = '0;
         hi   = '0;
         if (d >= 0 && d < PP_COLUMNS) begin
            lo = acc_col_t'(pp.pp_cols[d][WORD_LEN-1:0]);
         end
         if (d >= 1 && d <= PP_COLUMNS) begin
            hi = acc_col_t'(pp.pp_cols[d-1][PP_BIT_LEN-1:WORD_LEN]);
         end
         s = base ^ lo ^ hi;
         c = ((base & lo) | (base & hi) | (lo & hi)) << 1;
         acc_next[k] = s + c;
      end
   end

   // Low word of each column plus the carry bits of the column below
   always_comb begin
      for (int k = 0; k < PROD_ELEMENTS; k++) begin
         red[k].value = acc[k][BIT_LEN-1:0];
         // top coefficient keeps its whole value
         if (k < PROD_ELEMENTS - 1) begin
            red[k].part.carry = '0;
         end
         if (k > 0) begin
            red[k].value = red[k].value + coeff_t'(acc[k-1][ACC_BIT_LEN-1:WORD_LEN]);
         end
      end
   end

   always_ff @(posedge clk) begin
      reduce_pending <= pp.pp_valid && pp.pp_last;
      if (pp.pp_valid) begin
         acc <= acc_next;
      end
      if (reduce_pending) begin
         for (int k = 0; k < PROD_ELEMENTS; k++) begin
            out_data[k] <= red[k].value;
         end
      end
   end

endmodule

/* design/redundant_squarer.sv */
/*
 * Top level of the redundant squarer.
 * Takes an operand of NUM_ELEMENTS coefficients over a valid/ready input
 * and returns its full square as PROD_ELEMENTS coefficients over a
 * valid/ready output, five cycles after acceptance. One squaring at a time.
 */
`timescale 1ns/1ps

module redundant_squarer
   import sq_arith_pkg::*, sq_sched_pkg::*;
#(
   parameter int  WORD_LEN              = sq_arith_pkg::WORD_LEN,
   parameter int  BIT_LEN               = sq_arith_pkg::BIT_LEN,
   parameter int  NONREDUNDANT_ELEMENTS = sq_arith_pkg::NONREDUNDANT_ELEMENTS,
   parameter int  REDUNDANT_ELEMENTS    = sq_arith_pkg::REDUNDANT_ELEMENTS,
   parameter int  NUM_SEGMENTS          = sq_arith_pkg::NUM_SEGMENTS,
   localparam int NUM_ELEMENTS          = NONREDUNDANT_ELEMENTS + REDUNDANT_ELEMENTS,
   localparam int PROD_ELEMENTS         = 2 * NUM_ELEMENTS
)(
   input  logic   clk,
   input  logic   reset,
   input  logic   in_valid,
   output logic   in_ready,
   input  coeff_t in_data [NUM_ELEMENTS],
   output logic   out_valid,
   input  logic   out_ready,
   output coeff_t out_data [PROD_ELEMENTS]
);

   localparam int MUL_ELEMENTS = NONREDUNDANT_ELEMENTS / NUM_SEGMENTS + REDUNDANT_ELEMENTS;
   localparam int PP_COLUMNS   = 2 * MUL_ELEMENTS - 1;

   logic     load;
   logic     issue;
   seg_sel_t a_sel;
   seg_sel_t b_sel;
   logic     double;
   logic     first;
   logic     last;

   pp_if #(
      .COLUMNS     (PP_COLUMNS),
      .OFFSET_BITS ($clog2(PROD_ELEMENTS))
   ) pp ();

   square_sequencer i_sequencer (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .load      (load),
      .issue     (issue),
      .a_sel     (a_sel),
      .b_sel     (b_sel),
      .double    (double),
      .first     (first),
      .last      (last)
   );

   segment_multiplier #(
      .NONREDUNDANT_ELEMENTS (NONREDUNDANT_ELEMENTS),
      .REDUNDANT_ELEMENTS    (REDUNDANT_ELEMENTS),
      .NUM_SEGMENTS          (NUM_SEGMENTS)
   ) i_multiplier (
      .clk     (clk),
      .load    (load),
      .issue   (issue),
      .a_sel   (a_sel),
      .b_sel   (b_sel),
      .double  (double),
      .first   (first),
      .last    (last),
      .in_data (in_data),
      .pp      (pp.producer)
   );

   column_accumulator #(
      .WORD_LEN              (WORD_LEN),
      .BIT_LEN               (BIT_LEN),
      .NONREDUNDANT_ELEMENTS (NONREDUNDANT_ELEMENTS),
      .REDUNDANT_ELEMENTS    (REDUNDANT_ELEMENTS),
      .NUM_SEGMENTS          (NUM_SEGMENTS)
   ) i_accumulator (
      .clk      (clk),
      .pp       (pp.consumer),
      .out_data (out_data)
   );

endmodule

/* tests/tb_clock.sv */
/*
 * Clock and reset source for the squarer testbench.
 * Free-running clock of PERIOD_NS, reset held high for RESET_CYCLES edges.
 */
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 3
)(
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   initial begin
      reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* tests/redundant_squarer_sva.sv */
/*
 * Handshake assertions of the redundant squarer, bound into the top level.
 * A waiting result must hold, no operand is taken from acceptance until
 * the result has left, and reset clears out_valid.
 */
`timescale 1ns/1ps

module redundant_squarer_sva
   import sq_arith_pkg::*;
#(
   parameter int NUM_OUT = sq_arith_pkg::PROD_ELEMENTS
)(
   input logic   clk,
   input logic   reset,
   input logic   in_valid,
   input logic   in_ready,
   input logic   out_valid,
   input logic   out_ready,
   input coeff_t out_data [NUM_OUT]
);

   logic [NUM_OUT*BIT_LEN-1:0] out_flat;
   // Operand accepted and its result not yet taken
   logic                       busy;

   always_comb begin
      for (int k = 0; k < NUM_OUT; k++) begin
         out_flat[k*BIT_LEN +: BIT_LEN] = out_data[k];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end
      else if (in_valid && in_ready) begin
         busy <= 1'b1;
      end
      else if (out_valid && out_ready) begin
         busy <= 1'b0;
      end
   end

   // Result not taken stays as it is
   assert property (@(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_flat)))
      else $error("out_data or out_valid changed while out_ready was low");

   assert property (@(posedge clk) disable iff (reset) (busy || out_valid) |-> !in_ready)
      else $error("in_ready is high while a squaring or its result is pending");

   assert property (@(posedge clk) reset |=> !out_valid)
      else $error("out_valid is high in the cycle after reset");

endmodule

bind redundant_squarer redundant_squarer_sva #(
   .NUM_OUT (PROD_ELEMENTS)
) i_handshake_sva (
   .clk       (clk),
   .reset     (reset),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data)
);

/* tests/tb_redundant_squarer.sv */
/*
 * Testbench of the redundant squarer.
 * Applies a table of operands over the valid/ready input, holds out_ready
 * low for a per-row number of cycles and compares the integer value of each
 * result with the square of the operand value. Ends on a cycle limit.
 */
`timescale 1ns/1ps

module tb_redundant_squarer
   import sq_arith_pkg::*;
();

   localparam int NUM_FIXED   = 4;
   localparam int NUM_RANDOM  = 8;
   localparam int NUM_ROWS    = NUM_FIXED + NUM_RANDOM;
   localparam int MAX_STALL   = 4;
   localparam int LATENCY     = 5;
   localparam int CYCLE_LIMIT = NUM_ROWS * (LATENCY + MAX_STALL + 4) + 50;
   localparam logic [31:0] SEED = 32'd41796;
   // Wide enough for the square of any operand
   localparam int VALUE_LEN = 2 * (NUM_ELEMENTS * WORD_LEN + BIT_LEN);

   typedef logic [VALUE_LEN-1:0] value_t;

   logic   clk;
   logic   reset;
   logic   in_valid;
   logic   in_ready;
   coeff_t in_data [NUM_ELEMENTS];
   logic   out_valid;
   logic   out_ready;
   coeff_t out_data [PROD_ELEMENTS];

   coeff_t operand_table [NUM_ROWS][NUM_ELEMENTS];
   int     stall_table [NUM_ROWS];
   value_t expect_table [NUM_ROWS];

   int cycle_count;
   int errors;
   int tests_passed;
   int tests_failed;

   tb_clock #(
      .PERIOD_NS    (4),
      .RESET_CYCLES (3)
   ) i_clock (
      .clk   (clk),
      .reset (reset)
   );

   redundant_squarer i_dut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   // Integer value of a coefficient array, coefficient k weighted by 2^(WORD_LEN*k)
   function automatic value_t operand_value(input coeff_t c [NUM_ELEMENTS]);
      value_t v;
      v = '0;
      for (int k = 0; k < NUM_ELEMENTS; k++) begin
         v = v + (value_t'(c[k]) << (WORD_LEN * k));
      end
      return v;
   endfunction

   function automatic value_t product_value(input coeff_t c [PROD_ELEMENTS]);
      value_t v;
      v = '0;
      for (int k = 0; k < PROD_ELEMENTS; k++) begin
         v = v + (value_t'(c[k]) << (WORD_LEN * k));
      end
      return v;
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic fill_table();
      logic [31:0] rnd;
      rnd = SEED;
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int k = 0; k < NUM_ELEMENTS; k++) begin
            operand_table[r][k] = '0;
         end
      end
      stall_table[0] = 0;
      // All-ones words
      for (int k = 0; k < NUM_ELEMENTS; k++) begin
         operand_table[1][k] = coeff_t'(2 ** WORD_LEN - 1);
      end
      stall_table[1] = 1;
      // Carry bit set everywhere
      for (int k = 0; k < NUM_ELEMENTS - 1; k++) begin
         operand_table[2][k] = '1;
      end
      operand_table[2][NUM_ELEMENTS-1] = coeff_t'(2 ** WORD_LEN);
      stall_table[2] = 3;
      // Largest top coefficient whose square still fits the top output coefficient
      operand_table[3][NUM_ELEMENTS-1] = coeff_t'(17'h16a09);
      stall_table[3] = MAX_STALL;
      for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
         for (int k = 0; k < NUM_ELEMENTS - 1; k++) begin
            rnd = xorshift(rnd);
            operand_table[r][k] = coeff_t'(rnd);
         end
         // top limited to a word
         rnd = xorshift(rnd);
         operand_table[r][NUM_ELEMENTS-1] = coeff_t'(rnd[WORD_LEN-1:0]);
         rnd = xorshift(rnd);
         stall_table[r] = int'(rnd[2:0]) % (MAX_STALL + 1);
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         expect_table[r] = operand_value(operand_table[r]) * operand_value(operand_table[r]);
      end
   endtask

   task automatic check_held_result(input int row, input coeff_t held [PROD_ELEMENTS]);
      if (!out_valid) begin
         $display("Row %0d: out_valid dropped before the result was taken", row);
         errors++;
      end
      if (in_ready) begin
         $display("Row %0d: in_ready is high while the result waits", row);
         errors++;
      end
      for (int k = 0; k < PROD_ELEMENTS; k++) begin
         if (out_data[k] != held[k]) begin
            $display("Mismatch out_data[%0d]: got %h expected %h", k, out_data[k], held[k]);
            errors++;
         end
      end
   endtask

   task automatic run_row(input int row);
      int     errors_before;
      int     latency;
      int     carry_limit;
      coeff_t held [PROD_ELEMENTS];
      coeff_u view;
      value_t got;
      errors_before = errors;
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= operand_table[row];
      @(negedge clk);
      while (!in_ready) begin
         @(negedge clk);
      end
      // Acceptance edge
      @(posedge clk);
      in_valid <= 1'b0;
      latency = 0;
      @(negedge clk);
      while (!out_valid) begin
         if (in_ready) begin
            $display("Row %0d: in_ready is high while a squaring is in flight", row);
            errors++;
         end
         @(posedge clk);
         latency++;
         @(negedge clk);
      end
      if (latency != LATENCY) begin
         $display("Row %0d: out_valid rose %0d cycles after acceptance instead of %0d",
                  row, latency, LATENCY);
         errors++;
      end
      held = out_data;
      for (int s = 0; s < stall_table[row]; s++) begin
         @(posedge clk);
         @(negedge clk);
         check_held_result(row, held);
      end
      @(posedge clk);
      out_ready <= 1'b1;
      @(negedge clk);
      check_held_result(row, held);
      // Result leaves on the next edge
      got = product_value(out_data);
      if (got != expect_table[row]) begin
         $display("Mismatch out_data value: got %h expected %h", got, expect_table[row]);
         errors++;
      end
      for (int k = 0; k < PROD_ELEMENTS - 1; k++) begin
         view.value  = out_data[k];
         // Nothing below the lowest column
         carry_limit = (k == 0) ? 0 : 1;
         if (int'(view.part.carry) > carry_limit) begin
            $display("Mismatch out_data[%0d].carry: got %h expected at most %h",
                     k, view.part.carry, carry_limit);
            errors++;
         end
      end
      @(posedge clk);
      out_ready <= 1'b0;
      @(negedge clk);
      if (!in_ready || out_valid) begin
         $display("Row %0d: handshake did not return to idle after the result was taken", row);
         errors++;
      end
      if (errors == errors_before) begin
         tests_passed++;
         $display("Test row %0d (stall %0d): ok", row, stall_table[row]);
      end
      else begin
         tests_failed++;
         $display("Test row %0d (stall %0d): failed", row, stall_table[row]);
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      in_valid  <= 1'b0;
      out_ready <= 1'b0;
      for (int k = 0; k < NUM_ELEMENTS; k++) begin
         in_data[k] <= '0;
      end
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      fill_table();
      @(negedge clk);
      while (reset) begin
         @(negedge clk);
      end
      if (out_valid || !in_ready) begin
         $display("After reset out_valid is %0b and in_ready is %0b instead of 0 and 1",
                  out_valid, in_ready);
         errors++;
         tests_failed++;
         $display("Test reset state: failed");
      end
      else begin
         tests_passed++;
         $display("Test reset state: ok");
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end
      else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* files.f */
design/sq_arith_pkg.sv
design/sq_sched_pkg.sv
design/pp_if.sv
design/square_sequencer.sv
design/segment_multiplier.sv
design/column_accumulator.sv
design/redundant_squarer.sv
tests/tb_clock.sv
tests/redundant_squarer_sva.sv
tests/tb_redundant_squarer.sv

/* run.sh */
#!/bin/sh
# Build the squarer testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_redundant_squarer \
   -f files.f \
   -o sim_redundant_squarer

./obj_dir/sim_redundant_squarer | tee sim.log

if grep -qx '>>> PASS' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
